// ==== tb.f ====
src/dram_pkg.sv
src/burst_if.sv
src/dram_cmd_if.sv
src/axi_burst_tracker.sv
src/dram_bank_fsm.sv
src/dram_pin_driver.sv
src/dram_axi_slave.sv
tests/dram_model.sv
tests/tb_dram_axi_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_dram_axi_slave -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/tb_dram_axi_slave.sv ====
`timescale 1ns/1ps

module tb_dram_axi_slave
    import dram_pkg::*;
();

    logic dram_clk, dram_rst;
    logic [ID_W-1:0] awid, arid, bid, rid;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic [LEN_W-1:0] awlen, arlen;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rlast, rvalid, rready;
    logic [DATA_W-1:0] wdata, rdata, dram_d, dram_q;
    logic [STRB_W-1:0] wstrb, dram_wen;
    logic [1:0] bresp, rresp;
    logic dram_csn, dram_rasn, dram_casn, dram_valid;
    logic [DRAM_A_W-1:0] dram_a;

    logic [31:0] lfsr = 32'h96d5;
    logic [DATA_W-1:0] sb [logic [ADDR_W-1:0]];
    logic [ID_W-1:0] wr_id, rd_id;
    logic [ADDR_W-1:0] wr_base, rd_base;
    int wr_len, wr_beat, rd_len, rd_beat, b_taken;
    logic wr_busy;
    logic [ROW_W-1:0] last_commit_row = RESET_ROW;
    int data_errors, proto_errors, cycles;
    // 44 beats are issued over all tests
    int cycle_limit = 40 * 44 + 200;

    dram_axi_slave u_dram_axi_slave (.*);

    dram_model u_dram_model (.*);

    initial begin
        dram_clk = 1'b0;
        forever #2 dram_clk = ~dram_clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [ADDR_W-1:0] strobe_addr();
        if (dram_wen != 4'hF) begin
            return wr_base + 32'(4 * wr_beat);
        end
        return rd_base + 32'(4 * rd_beat);
    endfunction

    function automatic logic [ROW_W-1:0] row_of(input logic [ADDR_W-1:0] a);
        return a[22:12];
    endfunction

    function automatic logic [COL_W-1:0] col_of(input logic [ADDR_W-1:0] a);
        return a[11:2];
    endfunction

    always @(negedge dram_clk) begin
        if (!dram_csn && !dram_rasn && dram_wen == 4'h0) begin
            last_commit_row = dram_a;
        end
    end

    always @(posedge dram_clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Protocol checks
    assert property (@(posedge dram_clk) disable iff (dram_rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            proto_errors++;
            $display("mismatch rdata_hold expected %h actual %h", $past(rdata), rdata);
        end
    assert property (@(posedge dram_clk) disable iff (dram_rst)
        bvalid && !bready |=> bvalid && $stable(bid))
        else begin
            proto_errors++;
            $display("write response dropped or BID changed while BREADY was low");
        end
    assert property (@(posedge dram_clk) disable iff (dram_rst) bvalid |-> !awready)
        else begin
            proto_errors++;
            $display("AWREADY rose while a write response was pending");
        end
    assert property (@(posedge dram_clk) disable iff (dram_rst) awvalid |-> !arready)
        else begin
            proto_errors++;
            $display("ARREADY was high while AWVALID was high");
        end
    assert property (@(posedge dram_clk) disable iff (dram_rst)
        rvalid |-> rid == rd_id && rresp == RESP_OKAY)
        else begin
            proto_errors++;
            $display("mismatch rid expected %h actual %h rresp %b", rd_id, rid, rresp);
        end
    assert property (@(posedge dram_clk) disable iff (dram_rst)
        rvalid |-> rlast == (rd_beat == rd_len))
        else begin
            proto_errors++;
            $display("mismatch rlast expected %b actual %b", rd_beat == rd_len, rlast);
        end
    assert property (@(posedge dram_clk) disable iff (dram_rst)
        bvalid |-> bid == wr_id && bresp == RESP_OKAY && wr_beat == wr_len + 1)
        else begin
            proto_errors++;
            $display("mismatch bid expected %h actual %h beats %0d", wr_id, bid, wr_beat);
        end
    assert property (@(posedge dram_clk) disable iff (dram_rst)
        bvalid && bready |-> b_taken == 0)
        else begin
            proto_errors++;
            $display("more than one write response for one burst");
        end
    assert property (@(posedge dram_clk) disable iff (dram_rst)
        !dram_csn && !dram_casn |-> last_commit_row == row_of(strobe_addr())
            && dram_a == {1'b0, col_of(strobe_addr())})
        else begin
            proto_errors++;
            $display("mismatch col_strobe expected row %h col %h actual row %h a %h",
                row_of(strobe_addr()), col_of(strobe_addr()), last_commit_row, dram_a);
        end

    task automatic write_burst(input logic [7:0] id, input logic [31:0] base,
                               input logic [3:0] len, input bit full_strb, input bit hold_b);
        logic [31:0] data;
        logic [3:0] strb;
        logic [31:0] old;
        int held;
        bit done;
        data = rand_bits(32);
        strb = full_strb ? 4'hF : 4'(rand_bits(4));
        if (strb == 4'h0) strb = 4'h1;
        @(posedge dram_clk);
        awvalid <= 1'b1;
        awid    <= id;
        awaddr  <= base;
        awlen   <= len;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wlast   <= (len == 4'd0);
        wr_id   <= id;
        wr_base <= base;
        wr_len  <= int'(len);
        wr_beat <= 0;
        b_taken <= 0;
        wr_busy <= 1'b1;
        do @(negedge dram_clk); while (!awready);
        @(posedge dram_clk);
        awvalid <= 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
            do @(negedge dram_clk); while (!wready);
            @(posedge dram_clk);
            old = sb.exists(base + 32'(4 * beat)) ? sb[base + 32'(4 * beat)] : '0;
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) old[8*b +: 8] = data[8*b +: 8];
            end
            sb[base + 32'(4 * beat)] = old;
            wr_beat <= beat + 1;
            if (beat < int'(len)) begin
                data = rand_bits(32);
                strb = full_strb ? 4'hF : 4'(rand_bits(4));
                if (strb == 4'h0) strb = 4'h1;
                wdata <= data;
                wstrb <= strb;
                wlast <= (beat + 1 == int'(len));
            end else begin
                wvalid <= 1'b0;
                wlast  <= 1'b0;
            end
        end
        held = 0;
        done = 0;
        bready <= hold_b ? 1'b0 : 1'(rand_bits(1));
        while (!done) begin
            @(negedge dram_clk);
            done = bvalid && bready;
            @(posedge dram_clk);
            if (done) begin
                b_taken <= b_taken + 1;
                wr_busy <= 1'b0;
            end else if (hold_b) begin
                if (bvalid) held++;
                bready  <= (held >= 6);
                // Address channel busy while the response is held back
                awvalid <= (held < 6);
            end else begin
                bready <= 1'(rand_bits(1));
            end
        end
    endtask

    task automatic read_burst(input string name, input logic [7:0] id,
                              input logic [31:0] base, input logic [3:0] len,
                              input bit rand_ready);
        logic [31:0] exp;
        int beat;
        @(posedge dram_clk);
        arvalid <= 1'b1;
        arid    <= id;
        araddr  <= base;
        arlen   <= len;
        rd_id   <= id;
        rd_base <= base;
        rd_len  <= int'(len);
        rd_beat <= 0;
        rready  <= rand_ready ? 1'(rand_bits(1)) : 1'b1;
        do @(negedge dram_clk); while (!(arready && arvalid));
        assert (!wr_busy) else begin
            proto_errors++;
            $display("read address was taken before the pending write finished");
        end
        @(posedge dram_clk);
        arvalid <= 1'b0;
        beat = 0;
        while (beat <= int'(len)) begin
            @(negedge dram_clk);
            if (rvalid && rready) begin
                exp = sb[base + 32'(4 * beat)];
                assert (rdata == exp) else begin
                    data_errors++;
                    $display("mismatch %s beat %0d expected %h actual %h",
                        name, beat, exp, rdata);
                end
                beat++;
                @(posedge dram_clk);
                rd_beat <= beat;
            end else begin
                @(posedge dram_clk);
            end
            rready <= rand_ready ? 1'(rand_bits(1)) : 1'b1;
        end
        rready <= 1'b0;
    endtask

    initial begin
        dram_rst = 1'b1;
        {awid, awaddr, awlen, awvalid, wdata, wstrb, wlast, wvalid, bready} = '0;
        {arid, araddr, arlen, arvalid, rready} = '0;
        {wr_id, rd_id, wr_base, rd_base} = '0;
        {wr_len, wr_beat, rd_len, rd_beat, b_taken} = '0;
        wr_busy = 1'b0;
        repeat (2) @(posedge dram_clk);
        dram_rst <= 1'b0;

        // Full words, then partial strobes over them
        write_burst(8'h11, 32'h0000_1000, 4'd3, 1'b1, 1'b0);
        write_burst(8'h12, 32'h0000_1000, 4'd3, 1'b0, 1'b0);
        read_burst("strobe_merge", 8'h21, 32'h0000_1000, 4'd3, 1'b0);
        write_burst(8'h13, 32'h0000_2000, 4'd7, 1'b1, 1'b0);
        read_burst("random_rready", 8'h22, 32'h0000_2000, 4'd7, 1'b1);
        write_burst(8'h14, 32'h0000_3000, 4'd1, 1'b1, 1'b1);
        // 8 bytes below the row 4 to row 5 boundary
        write_burst(8'h15, 32'h0000_4ff8, 4'd3, 1'b1, 1'b0);
        read_burst("row_cross", 8'h23, 32'h0000_4ff8, 4'd3, 1'b1);
        fork
            write_burst(8'h16, 32'h0000_6000, 4'd1, 1'b1, 1'b0);
            read_burst("aw_ar_race", 8'h24, 32'h0000_1000, 4'd3, 1'b0);
        join
        repeat (5) @(posedge dram_clk);

        $display("errors: data %0d protocol %0d", data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/dram_model.sv ====
`timescale 1ns/1ps

module dram_model
    import dram_pkg::*;
(
    input  logic                dram_clk,
    input  logic                dram_rst,
    input  logic                dram_csn,
    input  logic                dram_rasn,
    input  logic                dram_casn,
    input  logic [STRB_W-1:0]   dram_wen,
    input  logic [DRAM_A_W-1:0] dram_a,
    input  logic [DATA_W-1:0]   dram_d,
    output logic [DATA_W-1:0]   dram_q,
    output logic                dram_valid
);

    logic [DATA_W-1:0] mem [logic [ROW_W+COL_W-1:0]];
    logic [ROW_W-1:0]  row;
    logic [ROW_W+COL_W-1:0] key;
    logic [DATA_W-1:0] word;
    int                lat;

    // Unwritten words carry their own row and column
    function automatic logic [DATA_W-1:0] stored(input logic [ROW_W+COL_W-1:0] k);
        if (mem.exists(k)) begin
            return mem[k];
        end
        return 32'h5a00_0000 ^ {11'b0, k};
    endfunction

    always @(posedge dram_clk) begin
        if (dram_rst) begin
            row        <= RESET_ROW;
            dram_q     <= '0;
            dram_valid <= 1'b0;
            lat        <= 0;
        end else if (dram_csn) begin
            dram_valid <= 1'b0;
            lat        <= 0;
        end else if (!dram_rasn) begin
            dram_valid <= 1'b0;
            lat        <= 0;
            // Commit strobe has all WEn low
            if (dram_wen == 4'h0) begin
                row <= dram_a;
            end
        end else if (!dram_casn) begin
            key        = {row, dram_a[COL_W-1:0]};
            dram_valid <= 1'b0;
            if (dram_wen != 4'hF) begin
                word = stored(key);
                for (int b = 0; b < STRB_W; b++) begin
                    if (!dram_wen[b]) begin
                        word[8*b +: 8] = dram_d[8*b +: 8];
                    end
                end
                mem[key] = word;
                lat      <= 0;
            end else begin
                dram_q <= stored(key);
                lat    <= 1;
            end
        end else if (lat == 3) begin
            dram_valid <= 1'b1;
            lat        <= 0;
        end else if (lat != 0) begin
            lat <= lat + 1;
        end
    end

endmodule

// ==== src/dram_axi_slave.sv ====
`timescale 1ns/1ps

module dram_axi_slave
    import dram_pkg::*;
(
    input  logic                dram_clk,
    input  logic                dram_rst,

    input  logic [ID_W-1:0]     awid,
    input  logic [ADDR_W-1:0]   awaddr,
    input  logic [LEN_W-1:0]    awlen,
    input  logic                awvalid,
    output logic                awready,

    input  logic [DATA_W-1:0]   wdata,
    input  logic [STRB_W-1:0]   wstrb,
    input  logic                wlast,
    input  logic                wvalid,
    output logic                wready,

    output logic [ID_W-1:0]     bid,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,

    input  logic [ID_W-1:0]     arid,
    input  logic [ADDR_W-1:0]   araddr,
    input  logic [LEN_W-1:0]    arlen,
    input  logic                arvalid,
    output logic                arready,

    output logic [ID_W-1:0]     rid,
    output logic [DATA_W-1:0]   rdata,
    output logic [1:0]          rresp,
    output logic                rlast,
    output logic                rvalid,
    input  logic                rready,

    output logic                dram_csn,
    output logic [STRB_W-1:0]   dram_wen,
    output logic                dram_rasn,
    output logic                dram_casn,
    output logic [DRAM_A_W-1:0] dram_a,
    output logic [DATA_W-1:0]   dram_d,
    input  logic [DATA_W-1:0]   dram_q,
    input  logic                dram_valid
);

    burst_if    burst_bus ();
    dram_cmd_if cmd_bus ();

    axi_burst_tracker u_tracker (
        .dram_clk (dram_clk),
        .dram_rst (dram_rst),
        .awid     (awid),
        .arid     (arid),
        .awaddr   (awaddr),
        .araddr   (araddr),
        .awlen    (awlen),
        .arlen    (arlen),
        .bus      (burst_bus.tracker)
    );

    dram_bank_fsm u_fsm (
        .dram_clk   (dram_clk),
        .dram_rst   (dram_rst),
        .awvalid    (awvalid),
        .arvalid    (arvalid),
        .wvalid     (wvalid),
        .wlast      (wlast),
        .bready     (bready),
        .rready     (rready),
        .dram_valid (dram_valid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .awready    (awready),
        .arready    (arready),
        .wready     (wready),
        .bvalid     (bvalid),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .bus        (burst_bus.fsm),
        .cmd        (cmd_bus.fsm)
    );

    dram_pin_driver u_driver (
        .dram_clk  (dram_clk),
        .dram_rst  (dram_rst),
        .cmd       (cmd_bus.driver),
        .dram_csn  (dram_csn),
        .dram_rasn (dram_rasn),
        .dram_casn (dram_casn),
        .dram_wen  (dram_wen),
        .dram_a    (dram_a),
        .dram_d    (dram_d)
    );

    // One burst in flight, so both IDs come from the same register
    assign bid   = burst_bus.burst_id;
    assign rid   = burst_bus.burst_id;
    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;
    assign rdata = dram_q;

endmodule

// ==== src/dram_pin_driver.sv ====
`timescale 1ns/1ps

module dram_pin_driver
    import dram_pkg::*;
(
    input  logic                dram_clk,
    input  logic                dram_rst,
    dram_cmd_if.driver          cmd,
    output logic                dram_csn,
    output logic                dram_rasn,
    output logic                dram_casn,
    output logic [STRB_W-1:0]   dram_wen,
    output logic [DRAM_A_W-1:0] dram_a,
    output logic [DATA_W-1:0]   dram_d
);

    always_ff @(posedge dram_clk) begin
        if (dram_rst) begin
            dram_csn  <= 1'b1;
            dram_rasn <= 1'b1;
            dram_casn <= 1'b1;
            dram_wen  <= '1;
            dram_a    <= '0;
            dram_d    <= '0;
        end else begin
            // Selected with all strobes high unless the op says otherwise
            dram_csn  <= 1'b0;
            dram_rasn <= 1'b1;
            dram_casn <= 1'b1;
            dram_wen  <= '1;
            case (cmd.op)
                op_row: begin
                    dram_rasn <= 1'b0;
                    dram_a    <= cmd.row;
                end
                op_row_hold, op_commit_hold: begin
                    dram_a <= cmd.row;
                end
                op_commit: begin
                    dram_rasn <= 1'b0;
                    dram_wen  <= '0;
                    dram_a    <= cmd.row;
                end
                op_col_write: begin
                    dram_casn <= 1'b0;
                    dram_wen  <= cmd.wmask;
                    dram_a    <= DRAM_A_W'(cmd.col);
                    dram_d    <= cmd.wdata;
                end
                op_col_read: begin
                    dram_casn <= 1'b0;
                    dram_a    <= DRAM_A_W'(cmd.col);
                end
                op_data_hold: begin
                    // address and data stay as they are
                end
                default: begin
                    dram_csn <= 1'b1;
                    dram_a   <= '0;
                    dram_d   <= '0;
                end
            endcase
        end
    end

endmodule

// ==== src/dram_bank_fsm.sv ====
`timescale 1ns/1ps

module dram_bank_fsm
    import dram_pkg::*;
(
    input  logic              dram_clk,
    input  logic              dram_rst,
    input  logic              awvalid,
    input  logic              arvalid,
    input  logic              wvalid,
    input  logic              wlast,
    input  logic              bready,
    input  logic              rready,
    input  logic              dram_valid,
    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,
    output logic              awready,
    output logic              arready,
    output logic              wready,
    output logic              bvalid,
    output logic              rvalid,
    output logic              rlast,
    burst_if.fsm              bus,
    dram_cmd_if.fsm           cmd
);

    bank_state_e        state;
    bank_state_e        state_next;
    logic [TIMER_W-1:0] row_cnt;
    logic [TIMER_W-1:0] commit_cnt;
    logic [TIMER_W-1:0] col_cnt;
    logic [ROW_W-1:0]   open_row;
    logic               entering;
    logic               row_hit;
    logic               next_hit;
    logic               w_hs;
    logic               r_hs;
    dram_addr_u         beat_addr;

    // Write wins when both address channels are valid
    assign awready = (state == idle) && awvalid;
    assign arready = (state == idle) && !awvalid;
    assign wready  = (state == wr_data) && (col_cnt == TIMER_W'(WDATA_WAIT));
    assign bvalid  = (state == wr_resp);
    assign rvalid  = (state == rd_data) && dram_valid;
    assign rlast   = (state == rd_data) && bus.last;

    assign w_hs = wvalid && wready;
    assign r_hs = rvalid && rready;

    assign bus.take_write = awready;
    assign bus.take_read  = arready && arvalid;
    assign bus.beat_done  = w_hs || r_hs;

    assign row_hit  = (bus.addr.fld.row == open_row);
    assign next_hit = (bus.next_addr.fld.row == open_row);
    assign entering = (state_next != state);

    // Address of the beat the next command belongs to
    assign beat_addr = bus.beat_done ? bus.next_addr : bus.addr;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (bus.take_write) begin
                    state_next = row_hit ? wr_col : wr_row;
                end else if (bus.take_read) begin
                    state_next = row_hit ? rd_col : rd_row;
                end
            end
            wr_row:    if (row_cnt == TIMER_W'(ROW_WAIT)) state_next = wr_commit;
            wr_commit: if (commit_cnt == TIMER_W'(COMMIT_WAIT)) state_next = wr_col;
            wr_col:    state_next = wr_data;
            wr_data: begin
                if (w_hs) begin
                    state_next = wlast ? wr_resp : (next_hit ? wr_gap : wr_row);
                end
            end
            wr_gap:    state_next = wr_col;
            wr_resp:   if (bready) state_next = idle;
            rd_row:    if (row_cnt == TIMER_W'(ROW_WAIT)) state_next = rd_commit;
            rd_commit: if (commit_cnt == TIMER_W'(COMMIT_WAIT)) state_next = rd_col;
            rd_col:    state_next = rd_data;
            rd_data: begin
                if (r_hs) begin
                    state_next = bus.last ? idle : (next_hit ? rd_col : rd_row);
                end
            end
            default:   state_next = idle;
        endcase
    end

    always_ff @(posedge dram_clk) begin
        if (dram_rst) begin
            state      <= idle;
            row_cnt    <= '0;
            commit_cnt <= '0;
            col_cnt    <= '0;
            open_row   <= RESET_ROW;
        end else begin
            state <= state_next;
            if (state_next inside {wr_row, rd_row}) begin
                row_cnt <= entering ? '0 : row_cnt + 1'b1;
            end
            if (state_next inside {wr_commit, rd_commit}) begin
                commit_cnt <= entering ? '0 : commit_cnt + 1'b1;
            end
            if (state_next == wr_col) begin
                col_cnt <= '0;
            end else if (state_next == wr_data && col_cnt != TIMER_W'(WDATA_WAIT)) begin
                col_cnt <= col_cnt + 1'b1;
            end
            // New row opens with the row strobe
            if ((state_next inside {wr_row, rd_row}) && entering) begin
                open_row <= beat_addr.fld.row;
            end
        end
    end

    // Command for the state entered at the next edge
    always_comb begin
        case (state_next)
            wr_row, rd_row:          cmd.op = entering ? op_row : op_row_hold;
            wr_commit, rd_commit:    cmd.op = entering ? op_commit : op_commit_hold;
            wr_col:                  cmd.op = op_col_write;
            rd_col:                  cmd.op = op_col_read;
            wr_data, wr_gap, rd_data: cmd.op = op_data_hold;
            default:                 cmd.op = op_deselect;
        endcase
    end

    assign cmd.row   = beat_addr.fld.row;
    assign cmd.col   = beat_addr.fld.col;
    assign cmd.wdata = wdata;
    assign cmd.wmask = ~wstrb;

endmodule

// ==== src/axi_burst_tracker.sv ====
`timescale 1ns/1ps

module axi_burst_tracker
    import dram_pkg::*;
(
    input  logic              dram_clk,
    input  logic              dram_rst,
    input  logic [ID_W-1:0]   awid,
    input  logic [ID_W-1:0]   arid,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic [ADDR_W-1:0] araddr,
    input  logic [LEN_W-1:0]  awlen,
    input  logic [LEN_W-1:0]  arlen,
    burst_if.tracker          bus
);

    dram_addr_u       addr_q;
    dram_addr_u       next_addr;
    logic [ID_W-1:0]  id_q;
    logic [LEN_W-1:0] len_q;
    logic [LEN_W-1:0] cnt_q;

    assign next_addr.word = addr_q.word + ADDR_W'(BEAT_BYTES);

    always_ff @(posedge dram_clk) begin
        if (dram_rst) begin
            len_q <= '0;
            cnt_q <= '0;
        end else if (bus.take_write) begin
            len_q <= awlen;
            cnt_q <= '0;
        end else if (bus.take_read) begin
            len_q <= arlen;
            cnt_q <= '0;
        end else if (bus.beat_done) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge dram_clk) begin
        if (bus.take_write) begin
            id_q        <= awid;
            addr_q.word <= awaddr;
        end else if (bus.take_read) begin
            id_q        <= arid;
            addr_q.word <= araddr;
        end else if (bus.beat_done) begin
            addr_q <= next_addr;
        end
    end

    // Pass the channel address straight through in the accept cycle,
    // so the row test can be made in idle
    always_comb begin
        if (bus.take_write) begin
            bus.addr.word = awaddr;
        end else if (bus.take_read) begin
            bus.addr.word = araddr;
        end else begin
            bus.addr = addr_q;
        end
    end

    assign bus.next_addr = next_addr;
    assign bus.burst_id  = id_q;
    assign bus.last      = (cnt_q == len_q);

endmodule

// ==== src/dram_cmd_if.sv ====
`timescale 1ns/1ps

interface dram_cmd_if
    import dram_pkg::*;
();

    // One command per cycle, registered onto the pins by the driver
    dram_op_e          op;
    logic [ROW_W-1:0]  row;
    logic [COL_W-1:0]  col;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wmask;

    modport fsm (
        output op, row, col, wdata, wmask
    );

    modport driver (
        input  op, row, col, wdata, wmask
    );

endinterface

// ==== src/burst_if.sv ====
`timescale 1ns/1ps

interface burst_if
    import dram_pkg::*;
();

    logic            take_write;
    logic            take_read;
    logic            beat_done;
    dram_addr_u      addr;
    dram_addr_u      next_addr;
    logic [ID_W-1:0] burst_id;
    logic            last;

    modport tracker (
        input  take_write, take_read, beat_done,
        output addr, next_addr, burst_id, last
    );

    modport fsm (
        output take_write, take_read, beat_done,
        input  addr, next_addr, burst_id, last
    );

endinterface

// ==== src/dram_pkg.sv ====
package dram_pkg;

    // AXI side
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int ID_W   = 8;
    localparam int LEN_W  = 4;

    // DRAM side
    localparam int DRAM_A_W = 11;
    localparam int ROW_W    = 11;
    localparam int COL_W    = 10;

    // Bytes per beat, bursts are always incrementing
    localparam int BEAT_BYTES = 4;

    // Wait counts between strobes
    localparam int TIMER_W     = 3;
    localparam int ROW_WAIT    = 4;
    localparam int COMMIT_WAIT = 4;
    localparam int WDATA_WAIT  = 4;

    localparam logic [ROW_W-1:0] RESET_ROW = 11'd1327;
    localparam logic [1:0]       RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [8:0]       upper;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        logic [1:0]       byte_off;
    } dram_addr_fields_t;

    // Byte address, or the same word split into DRAM fields
    typedef union packed {
        logic [ADDR_W-1:0] word;
        dram_addr_fields_t fld;
    } dram_addr_u;

    typedef enum logic [3:0] {
        idle,
        wr_row,
        wr_commit,
        wr_col,
        wr_data,
        wr_gap,
        wr_resp,
        rd_row,
        rd_commit,
        rd_col,
        rd_data
    } bank_state_e;

    typedef enum logic [2:0] {
        op_deselect,
        op_row,
        op_row_hold,
        op_commit,
        op_commit_hold,
        op_col_write,
        op_col_read,
        op_data_hold
    } dram_op_e;

endpackage
